// ==== Makefile ====
# Verilator build and run of the pipeline testbench
VERILATOR    ?= verilator
TOP          ?= pipe_tb
FILELIST     ?= src.f
OBJ_DIR      ?= obj_dir
LOG          ?= sim.log
SEED         ?= 61
EXTRA_VFLAGS ?=
SIM_ARGS     ?= +verilator+error+limit+1000

FAIL_MSG := Test failed
PASS_MSG := Test completed successfully
VFLAGS   := --binary --timing --assert --top-module $(TOP) -GSEED=$(SEED) \
            --Mdir $(OBJ_DIR) -o $(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overrides: VERILATOR TOP FILELIST OBJ_DIR LOG SEED EXTRA_VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA_VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL, no verdict in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== back_end.sv ====
// execute, memory and writeback stages of the pipeline
// execute forms the data address from the I or S immediate (rs1 is x0),
// memory runs the data-port access, writeback reports retired instructions
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module back_end
import rv32i_types::*;
import pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        exe_go,
    input  logic        mem_go,
    input  logic        wb_go,

    // decoded instruction from the front end
    input  rv32i_word   de_pc,
    input  rv32i_word   de_instr,
    input  rv32i_opcode cw_opcode,
    input  funct3_t     cw_funct3,
    input  funct7_t     cw_funct7,

    input  logic        dmem_resp,

    output logic        exe_rdy,
    output logic        mem_rdy,
    output logic        wb_rdy,
    output logic        mem_pending,

    // data port, levels held until the response
    output logic        dmem_read,
    output logic        dmem_write,
    output rv32i_word   dmem_addr,

    output logic        retire,
    output rv32i_word   retire_pc,
    output rv32i_word   retire_instr
);

    logic de_valid;
    logic ld_ok;
    logic st_ok;
    logic [`DMEM_AWIDTH-1:0] imm_next;

    logic      exe_valid;
    logic      exe_is_load;
    logic      exe_is_store;
    rv32i_word exe_pc;
    rv32i_word exe_instr;
    logic [`DMEM_AWIDTH-1:0] exe_imm;

    mem_state_t mem_state;
    mem_state_t mem_state_next;
    logic      mem_valid;
    logic      mem_is_load;
    logic      mem_is_store;
    logic      mem_access;
    logic      mem_ack;
    rv32i_word mem_pc;
    rv32i_word mem_instr;
    logic [`DMEM_AWIDTH-1:0] mem_addr;

    logic      wb_valid;
    rv32i_word wb_pc;
    rv32i_word wb_instr;

    // every real opcode is nonzero
    assign de_valid = |cw_opcode;

    // only legal widths touch the data port
    assign ld_ok = (cw_opcode == op_load) && (cw_funct3 != 3'b011) && (cw_funct3 < 3'b110);
    assign st_ok = (cw_opcode == op_store) && (cw_funct3 < 3'b011);

    // imm[11:5] is funct7 in both I and S formats
    always_comb begin : imm_gen
        case (cw_opcode)
            op_load, op_imm, op_jalr:
                imm_next = {{(`DMEM_AWIDTH-12){cw_funct7[6]}}, cw_funct7, de_instr[24:20]};
            op_store:
                imm_next = {{(`DMEM_AWIDTH-12){cw_funct7[6]}}, cw_funct7, de_instr[11:7]};
            default:
                imm_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin : exe_ctrl
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (exe_go) begin
            exe_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin : exe_data
        if (exe_go) begin
            exe_pc       <= de_pc;
            exe_instr    <= de_instr;
            exe_is_load  <= ld_ok;
            exe_is_store <= st_ok;
            exe_imm      <= imm_next;
        end
    end

    assign exe_rdy = exe_valid;

    // memory stage
    assign mem_access  = mem_valid && (mem_is_load || mem_is_store);
    assign mem_ack     = (mem_state == mem_wait) && dmem_resp;
    assign mem_pending = mem_access && !mem_ack;
    // finishes in the response cycle, or at once without an access
    assign mem_rdy     = mem_valid && !mem_pending;

    always_comb begin : mem_fsm
        mem_state_next = mem_state;
        case (mem_state)
            mem_wait: begin
                if (dmem_resp) begin
                    mem_state_next = mem_done;
                end
            end
            mem_idle, mem_done: begin
                // issue for what is loaded now, or for what sat out mem_done
                if (mem_go) begin
                    if (exe_valid && (exe_is_load || exe_is_store)) begin
                        mem_state_next = mem_wait;
                    end else begin
                        mem_state_next = mem_idle;
                    end
                end else if (mem_access) begin
                    mem_state_next = mem_wait;
                end else begin
                    mem_state_next = mem_idle;
                end
            end
            default: mem_state_next = mem_idle;
        endcase
    end

    always_ff @(posedge clk) begin : mem_ctrl
        if (rst) begin
            mem_state <= mem_idle;
            mem_valid <= 1'b0;
        end else begin
            mem_state <= mem_state_next;
            if (mem_go) begin
                mem_valid <= exe_valid;
            end
        end
    end

    always_ff @(posedge clk) begin : mem_data
        if (mem_go) begin
            mem_pc       <= exe_pc;
            mem_instr    <= exe_instr;
            mem_is_load  <= exe_is_load;
            mem_is_store <= exe_is_store;
            mem_addr     <= exe_imm;
        end
    end

    // mem_go is low while waiting, so the address stays put
    assign dmem_read  = (mem_state == mem_wait) && mem_is_load;
    assign dmem_write = (mem_state == mem_wait) && mem_is_store;
    assign dmem_addr  = mem_addr;

    // writeback, one cycle per retired instruction
    always_ff @(posedge clk) begin : wb_ctrl
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (wb_go) begin
            wb_valid <= mem_rdy;
        end
    end

    always_ff @(posedge clk) begin : wb_data
        if (wb_go) begin
            wb_pc    <= mem_pc;
            wb_instr <= mem_instr;
        end
    end

    assign wb_rdy       = wb_valid;
    assign retire       = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_instr = wb_instr;

endmodule : back_end

`default_nettype wire

// ==== front_end.sv ====
// fetch and decode stages of the pipeline
// the pc walks the instruction port, decode presents the control word
// both registers move only on their go level from pipe_control
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module front_end
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_go,
    input  logic        de_go,

    // instruction port, answered in the same cycle
    input  rv32i_word   imem_rdata,
    output rv32i_word   imem_addr,

    output logic        fetch_rdy,
    output logic        de_rdy,

    // decoded instruction towards execute
    output rv32i_word   de_pc,
    output rv32i_word   de_instr,
    output rv32i_opcode cw_opcode,
    output funct3_t     cw_funct3,
    output funct7_t     cw_funct7
);

    rv32i_word pc;
    rv32i_word fetch_pc;
    rv32i_word fetch_instr;
    logic      fetch_valid;
    logic      de_valid;

    assign imem_addr = pc;

    // program counter, one word per fetch
    always_ff @(posedge clk) begin : pc_reg
        if (rst) begin
            pc <= `PIPE_RESET_PC;
        end else if (fetch_go) begin
            pc <= pc + rv32i_word'(`PIPE_PC_STEP);
        end
    end

    // fetch register valid
    // the port always answers, so every fetch is valid
    always_ff @(posedge clk) begin : fetch_ctrl
        if (rst) begin
            fetch_valid <= 1'b0;
        end else if (fetch_go) begin
            fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : fetch_data
        if (fetch_go) begin
            fetch_pc    <= pc;
            fetch_instr <= imem_rdata;
        end
    end

    // decode register
    // an empty fetch register turns into a bubble here
    always_ff @(posedge clk) begin : de_ctrl
        if (rst) begin
            de_valid <= 1'b0;
        end else if (de_go) begin
            de_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin : de_data
        if (de_go) begin
            de_pc    <= fetch_pc;
            de_instr <= fetch_instr;
        end
    end

    // control word, all zero while decode is empty
    // a zero opcode marks the bubble for execute
    always_comb begin : cw_gen
        cw_opcode = rv32i_opcode'(7'b0);
        cw_funct3 = '0;
        cw_funct7 = '0;
        if (de_valid) begin
            cw_opcode = rv32i_opcode'(de_instr[6:0]);
            cw_funct3 = de_instr[14:12];
            cw_funct7 = de_instr[31:25];
        end
    end

    // nothing to wait on in these stages
    assign fetch_rdy = fetch_valid;
    assign de_rdy    = de_valid;

endmodule : front_end

`default_nettype wire

// ==== pipe_assert.sv ====
// concurrent checks on the data port and the stage go levels
// bound into pipe_core where the control and back end nets meet
`timescale 1ns/1ps
`default_nettype none

module pipe_assert
import rv32i_types::*;
(
    input logic      clk,
    input logic      rst,
    input logic      fetch_go,
    input logic      de_go,
    input logic      exe_go,
    input logic      mem_go,
    input logic      wb_go,
    input logic      mem_pending,
    input logic      dmem_read,
    input logic      dmem_write,
    input logic      dmem_resp,
    input rv32i_word dmem_addr
);

    // failed checks so far
    int   fail_count = 0;
    logic any_go;
    logic req;

    assign any_go = fetch_go | de_go | exe_go | mem_go | wb_go;
    assign req    = dmem_read | dmem_write;

    // request levels and address frozen until the response
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (req && !dmem_resp) |=> (req && $stable(dmem_read) && $stable(dmem_write)
            && $stable(dmem_addr)))
    else begin
        $error("data request changed before its response");
        fail_count++;
    end

    // nothing moves in reset or in the cycle right after it
    go_in_reset: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !any_go)
    else begin
        $error("stage go high in reset or in the first cycle after it");
        fail_count++;
    end

    // memory register stays put while its access is open
    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_pending |=> $stable(dmem_addr))
    else begin
        $error("memory stage loaded while an access was pending");
        fail_count++;
    end

    one_kind: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write))
    else begin
        $error("read and write requested together");
        fail_count++;
    end

endmodule : pipe_assert

bind pipe_core pipe_assert assert0 (
    .clk         (clk),
    .rst         (rst),
    .fetch_go    (fetch_go),
    .de_go       (de_go),
    .exe_go      (exe_go),
    .mem_go      (mem_go),
    .wb_go       (wb_go),
    .mem_pending (mem_pending),
    .dmem_read   (dmem_read),
    .dmem_write  (dmem_write),
    .dmem_resp   (dmem_resp),
    .dmem_addr   (dmem_addr)
);

`default_nettype wire

// ==== pipe_control.sv ====
// stall policy of the five-stage pipeline
// turns per-stage ready levels and the pending data access into go levels
// every stage register moves only when its go is high
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module pipe_control
import pipe_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // ready levels, high when the stage holds a finished instruction
    input  logic fetch_rdy,
    input  logic de_rdy,
    input  logic exe_rdy,
    input  logic mem_rdy,
    input  logic wb_rdy,

    // memory stage holds a load or store without its response
    input  logic mem_pending,

    // load levels for the stage registers
    output logic fetch_go,
    output logic de_go,
    output logic exe_go,
    output logic mem_go,
    output logic wb_go
);

    stage_vec_t rdy;
    stage_vec_t go;
    // reset seen on the previous edge
    logic rst_q;

    assign rdy = {fetch_rdy, de_rdy, exe_rdy, mem_rdy, wb_rdy};

    // keeps the pipeline parked one extra cycle after reset drops
    always_ff @(posedge clk) begin
        rst_q <= rst;
    end

    always_comb begin : go_ctrl
        go = '0;
        if (!(rst || rst_q)) begin
            // front stages hold only when the access is pending and
            // there is no bubble between them and memory to fill
            go[`STG_FETCH] = !(mem_pending && (&rdy[`STG_FETCH:`STG_EXE]));
            go[`STG_DE]    = !(mem_pending && (&rdy[`STG_DE:`STG_EXE]));
            go[`STG_EXE]   = !(mem_pending && rdy[`STG_EXE]);

            // memory takes execute's work, or hands its own on to writeback
            // never while the data port is busy
            go[`STG_MEM]   = !mem_pending && (rdy[`STG_EXE] || rdy[`STG_MEM]);

            // writeback takes a finished instruction, or drops the one it retired
            go[`STG_WB]    = rdy[`STG_MEM] || rdy[`STG_WB];
        end
    end

    assign fetch_go = go[`STG_FETCH];
    assign de_go    = go[`STG_DE];
    assign exe_go   = go[`STG_EXE];
    assign mem_go   = go[`STG_MEM];
    assign wb_go    = go[`STG_WB];

endmodule : pipe_control

`default_nettype wire

// ==== pipe_core.sv ====
// top of the pipeline sequencing core
// instruction port in front, data port and retire report at the back
// pipe_control decides every stage move from the ready levels
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module pipe_core
import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction port
    input  rv32i_word imem_rdata,
    output rv32i_word imem_addr,

    // data port
    input  logic      dmem_resp,
    output logic      dmem_read,
    output logic      dmem_write,
    output rv32i_word dmem_addr,

    // retire report
    output logic      retire,
    output rv32i_word retire_pc,
    output rv32i_word retire_instr
);

    // stage handshake levels
    logic fetch_rdy, de_rdy, exe_rdy, mem_rdy, wb_rdy;
    logic fetch_go, de_go, exe_go, mem_go, wb_go;
    logic mem_pending;

    // decode towards execute
    rv32i_word   de_pc;
    rv32i_word   de_instr;
    rv32i_opcode cw_opcode;
    funct3_t     cw_funct3;
    funct7_t     cw_funct7;

    pipe_control control0 (
        .clk         (clk),
        .rst         (rst),
        .fetch_rdy   (fetch_rdy),
        .de_rdy      (de_rdy),
        .exe_rdy     (exe_rdy),
        .mem_rdy     (mem_rdy),
        .wb_rdy      (wb_rdy),
        .mem_pending (mem_pending),
        .fetch_go    (fetch_go),
        .de_go       (de_go),
        .exe_go      (exe_go),
        .mem_go      (mem_go),
        .wb_go       (wb_go)
    );

    front_end front0 (
        .clk        (clk),
        .rst        (rst),
        .fetch_go   (fetch_go),
        .de_go      (de_go),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .fetch_rdy  (fetch_rdy),
        .de_rdy     (de_rdy),
        .de_pc      (de_pc),
        .de_instr   (de_instr),
        .cw_opcode  (cw_opcode),
        .cw_funct3  (cw_funct3),
        .cw_funct7  (cw_funct7)
    );

    back_end back0 (
        .clk          (clk),
        .rst          (rst),
        .exe_go       (exe_go),
        .mem_go       (mem_go),
        .wb_go        (wb_go),
        .de_pc        (de_pc),
        .de_instr     (de_instr),
        .cw_opcode    (cw_opcode),
        .cw_funct3    (cw_funct3),
        .cw_funct7    (cw_funct7),
        .dmem_resp    (dmem_resp),
        .exe_rdy      (exe_rdy),
        .mem_rdy      (mem_rdy),
        .wb_rdy       (wb_rdy),
        .mem_pending  (mem_pending),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr)
    );

endmodule : pipe_core

`default_nettype wire

// ==== pipe_ctrl_pkg.sv ====
// types for the stage sequencing: the per-stage ready/go vector and
// the memory-stage access states; import with pipe_ctrl_pkg::*
`default_nettype none
`include "pipe_defines.svh"

package pipe_ctrl_pkg;

    // one bit per stage
    // fetch is the msb, writeback the lsb
    typedef logic [`PIPE_NSTAGES-1:0] stage_vec_t;

    // memory stage access sequencing
    typedef enum logic [1:0] {
        // nothing outstanding on the data port
        mem_idle = 2'b00,
        // request driven, waiting for the response pulse
        mem_wait = 2'b01,
        // response just taken, request held low this cycle
        mem_done = 2'b10
    } mem_state_t;

endpackage : pipe_ctrl_pkg

`default_nettype wire

// ==== pipe_defines.svh ====
// widths and fixed constants shared by the pipeline packages and RTL
// include wherever a bus is sized or a stage bit is picked out of a stage vector
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// instruction word and data-port address
`define PIPE_XLEN 32
`define DMEM_AWIDTH 32

// fetch sequencing
`define PIPE_RESET_PC 32'h0000_0000
`define PIPE_PC_STEP 4

// stage count, and bit positions inside a stage vector
`define PIPE_NSTAGES 5
`define STG_FETCH 4
`define STG_DE 3
`define STG_EXE 2
`define STG_MEM 1
`define STG_WB 0

`endif

// ==== pipe_tb.sv ====
// testbench for pipe_core with an instruction ROM built from a table,
// a data-port responder, a retire monitor and a watchdog
// each table row is a word, its access kind, expected address and response delay
`timescale 1ns/1ps
`default_nettype none

module pipe_tb
import rv32i_types::*;
#(
    parameter int SEED = 61
);

    localparam int        NENT       = 18;
    localparam int        CLK_HALF   = 2;
    localparam int        RST_CYCLES = 3;
    localparam rv32i_word NOP_WORD   = 32'h0000_0013;
    localparam int        KIND_NONE  = 0;
    localparam int        KIND_LOAD  = 1;
    localparam int        KIND_STORE = 2;

    logic      clk;
    logic      rst;
    rv32i_word imem_rdata;
    rv32i_word imem_addr;
    logic      dmem_resp;
    logic      dmem_read;
    logic      dmem_write;
    rv32i_word dmem_addr;
    logic      retire;
    rv32i_word retire_pc;
    rv32i_word retire_instr;

    // program table
    rv32i_word tbl_instr [NENT];
    int        tbl_kind  [NENT];
    rv32i_word tbl_addr  [NENT];
    int        tbl_delay [NENT];
    int        nfill = 0;

    int     errors = 0;
    int     checks = 0;
    int     retired = 0;
    int     mem_seen = 0;
    int     mem_scan = 0;
    int     mem_total = 0;
    int     cycle = 0;
    int     last_ret = 0;
    integer seed;

    pipe_core dut0 (
        .clk          (clk),
        .rst          (rst),
        .imem_rdata   (imem_rdata),
        .imem_addr    (imem_addr),
        .dmem_resp    (dmem_resp),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic add_entry(input rv32i_word instr, input int kind,
                             input rv32i_word addr, input int delay);
        tbl_instr[nfill] = instr;
        tbl_kind[nfill]  = kind;
        tbl_addr[nfill]  = addr;
        tbl_delay[nfill] = delay;
        nfill++;
    endtask

    // delay 0 means a random 1..4 cycles
    task automatic fill_table();
        add_entry(32'h0050_0093, KIND_NONE, 32'h0, 0);          // addi x1,x0,5
        add_entry(32'hFFF0_4413, KIND_NONE, 32'h0, 0);          // xori x8,x0,-1
        add_entry(32'h0020_8333, KIND_NONE, 32'h0, 0);          // add x6,x1,x2
        add_entry(32'h1234_53B7, KIND_NONE, 32'h0, 0);          // lui x7,0x12345
        add_entry(32'h0400_2103, KIND_LOAD, 32'h0000_0040, 1);  // lw x2,64(x0)
        add_entry(32'h0000_0013, KIND_NONE, 32'h0, 0);          // nop
        add_entry(32'h0210_2223, KIND_STORE, 32'h0000_0024, 0); // sw x1,36(x0)
        // long wait that everything behind it has to sit out
        add_entry(32'hFFC0_2183, KIND_LOAD, 32'hFFFF_FFFC, 9);  // lw x3,-4(x0)
        add_entry(32'h0020_8333, KIND_NONE, 32'h0, 0);          // add x6,x1,x2
        add_entry(32'h0050_0093, KIND_NONE, 32'h0, 0);          // addi x1,x0,5
        // four accesses back to back
        add_entry(32'hFE20_2823, KIND_STORE, 32'hFFFF_FFF0, 2); // sw x2,-16(x0)
        add_entry(32'h7FF0_0203, KIND_LOAD, 32'h0000_07FF, 0);  // lb x4,2047(x0)
        add_entry(32'h8000_5283, KIND_LOAD, 32'hFFFF_F800, 6);  // lhu x5,-2048(x0)
        add_entry(32'h0030_00A3, KIND_STORE, 32'h0000_0001, 1); // sb x3,1(x0)
        add_entry(32'h0000_0013, KIND_NONE, 32'h0, 0);          // nop
        add_entry(32'hFFF0_4413, KIND_NONE, 32'h0, 0);          // xori x8,x0,-1
        add_entry(32'h0020_8333, KIND_NONE, 32'h0, 0);          // add x6,x1,x2
        add_entry(32'h1234_53B7, KIND_NONE, 32'h0, 0);          // lui x7,0x12345
    endtask

    // beyond the table the ROM answers with nops
    function automatic rv32i_word rom_word(input rv32i_word addr);
        rv32i_word idx;
        idx = addr >> 2;
        if (idx < rv32i_word'(NENT)) begin
            return tbl_instr[idx];
        end
        return NOP_WORD;
    endfunction

    function automatic int next_mem_entry(input int from);
        int k;
        k = from;
        while (k < NENT && tbl_kind[k] == KIND_NONE) begin
            k++;
        end
        return k;
    endfunction

    task automatic compare_word(input string name, input rv32i_word got, input rv32i_word exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expect_idle_outputs();
        compare_flag("retire", retire, 1'b0);
        compare_flag("dmem_read", dmem_read, 1'b0);
        compare_flag("dmem_write", dmem_write, 1'b0);
        // fetch stays parked at pc 0
        compare_word("imem_addr", imem_addr, 32'h0000_0000);
    endtask

    task automatic print_counts();
        $display("checks %0d  errors %0d  assertion failures %0d  retired %0d of %0d",
                 checks, errors, dut0.assert0.fail_count, retired, NENT);
    endtask

    // instruction port looked up from the registered pc
    always @(negedge clk) begin
        imem_rdata <= rom_word(imem_addr);
    end

    // checks retire order, words and back-to-back retirement of plain instructions
    always @(negedge clk) begin : retire_monitor
        if (!rst && retire === 1'b1 && retired < NENT) begin
            compare_word("retire_pc", retire_pc, rv32i_word'(retired * 4));
            compare_word("retire_instr", retire_instr, tbl_instr[retired]);
            if (retired > 0 && tbl_kind[retired] == KIND_NONE
                    && tbl_kind[retired-1] == KIND_NONE) begin
                checks++;
                assert (cycle - last_ret == 1) else begin
                    errors++;
                    $display("pc %h retired %0d cycles after the one before it, not back to back",
                             retire_pc, cycle - last_ret);
                end
            end
            last_ret = cycle;
            retired++;
        end
    end

    // data-port responder for accesses in program order
    initial begin : responder
        int k;
        int d;
        forever begin
            @(negedge clk);
            if (!rst && (dmem_read === 1'b1 || dmem_write === 1'b1)) begin
                k = next_mem_entry(mem_scan);
                d = 1;
                checks++;
                assert (k < NENT) else begin
                    errors++;
                    $display("data request at address %h with no memory instruction left",
                             dmem_addr);
                end
                if (k < NENT) begin
                    compare_flag("dmem_read", dmem_read, tbl_kind[k] == KIND_LOAD);
                    compare_flag("dmem_write", dmem_write, tbl_kind[k] == KIND_STORE);
                    compare_word("dmem_addr", dmem_addr, tbl_addr[k]);
                    mem_scan = k + 1;
                    mem_seen++;
                    d = tbl_delay[k];
                    if (d == 0) begin
                        d = 1 + int'({$random(seed)} % 32'd4);
                    end
                end
                repeat (d - 1) @(negedge clk);
                dmem_resp = 1'b1;
                @(negedge clk);
                dmem_resp = 1'b0;
                // request gone in the cycle after the response
                compare_flag("dmem_read", dmem_read, 1'b0);
                compare_flag("dmem_write", dmem_write, 1'b0);
            end
        end
    end

    // run limit from the table length and the response delays
    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = 20 * NENT + RST_CYCLES;
        for (int i = 0; i < NENT; i++) begin
            if (tbl_kind[i] != KIND_NONE) begin
                limit += (tbl_delay[i] == 0) ? 4 : tbl_delay[i];
            end
        end
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d instructions retired",
                 limit, retired, NENT);
        print_counts();
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int total;
        clk = 1'b0;
        rst = 1'b1;
        imem_rdata = NOP_WORD;
        dmem_resp = 1'b0;
        seed = SEED;
        fill_table();
        for (int i = 0; i < NENT; i++) begin
            if (tbl_kind[i] != KIND_NONE) begin
                mem_total++;
            end
        end
        // quiet outputs through reset and the cycle after
        repeat (RST_CYCLES) begin
            @(negedge clk);
            expect_idle_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        expect_idle_outputs();
        wait (retired == NENT);
        @(negedge clk);
        checks++;
        assert (mem_seen == mem_total) else begin
            errors++;
            $display("expected %0d data requests but the responder saw %0d",
                     mem_total, mem_seen);
        end
        total = errors + dut0.assert0.fail_count;
        print_counts();
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : pipe_tb

`default_nettype wire

// ==== rv32i_types.sv ====
// instruction-level types for the fetch, decode and execute logic
// modules pick these up with rv32i_types::* in their header
`default_nettype none
`include "pipe_defines.svh"

package rv32i_types;

    // one instruction or one address
    typedef logic [`PIPE_XLEN-1:0] rv32i_word;

    // function fields of the base encoding
    // funct3 sits at [14:12], funct7 at [31:25]
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        // u-type
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        // j-type
        op_jal   = 7'b1101111,
        // i-type jump
        op_jalr  = 7'b1100111,
        // b-type
        op_br    = 7'b1100011,
        // i-type load
        op_load  = 7'b0000011,
        // s-type
        op_store = 7'b0100011,
        // alu with immediate
        op_imm   = 7'b0010011,
        // alu register-register
        op_reg   = 7'b0110011
    } rv32i_opcode;

endpackage : rv32i_types

`default_nettype wire

// ==== src.f ====
+incdir+.
rv32i_types.sv
pipe_ctrl_pkg.sv
pipe_control.sv
front_end.sv
back_end.sv
pipe_core.sv
pipe_assert.sv
pipe_tb.sv
